// File: mmio_pkg.sv
package mmio_pkg;

  // Bus widths
  localparam int data_w = 32;  // Wishbone and register data
  localparam int adr_w = 32;   // Wishbone byte address

  // External register file filled over SPI
  localparam int reg_count = 32;
  localparam int reg_addr_w = 5;

  // Scratch data RAM
  localparam int ram_words = 256;
  localparam int ram_addr_w = 8;

  // Address map, byte addresses, inclusive bounds
  localparam logic [adr_w-1:0] ram_base = 32'h0000_0000;
  localparam logic [adr_w-1:0] ram_limit = 32'h0000_03fc;  // Last RAM word
  localparam logic [adr_w-1:0] reg_base = 32'h0000_0400;
  localparam logic [adr_w-1:0] reg_limit = 32'h0000_047c;  // Register 31

  // ESP32 frame layout
  // Two index nibbles (low 5 bits used), then eight data nibbles MSB first
  localparam int frame_nibbles = 10;
  localparam int addr_nibbles = 2;

  // Target of one bus access
  typedef enum logic [1:0] {
    region_ram,   // Scratch RAM
    region_reg,   // Register window, read-only from the CPU
    region_none   // Unmapped, decoder answers
  } region_t;

endpackage

// File: bus_ifs.sv
// Decoder to external register file, read path only
interface reg_read_if;
  import mmio_pkg::*;

  logic req;                   // One-cycle pulse
  logic [reg_addr_w-1:0] addr; // Register index
  logic [data_w-1:0] data;     // Valid with ack
  logic ack;                   // One cycle after req

  modport requester (output req, addr, input data, ack);
  modport responder (input req, addr, output data, ack);

endinterface

// Decoder to scratch RAM
interface ram_port_if;
  import mmio_pkg::*;

  logic req;                   // One-cycle pulse
  logic we;                    // Write when set, read otherwise
  logic [ram_addr_w-1:0] addr; // Word index
  logic [data_w-1:0] wdata;
  logic [data_w-1:0] rdata;    // Valid with ack on reads
  logic ack;

  modport requester (output req, we, addr, wdata, input rdata, ack);
  modport responder (input req, we, addr, wdata, output rdata, ack);

endinterface

// File: esp_spi_receiver.sv
module esp_spi_receiver #(
  parameter int SCLK_DIV = 4  // clk cycles per sclk period, even, >= 2
) (
  input  logic clk,
  input  logic reset,
  input  logic cs_n,
  input  logic [3:0] esp_data,
  output logic sclk,
  output logic wr_en,
  output logic [mmio_pkg::reg_addr_w-1:0] wr_addr,
  output logic [mmio_pkg::data_w-1:0] wr_data
);
  import mmio_pkg::*;

  localparam int half = SCLK_DIV / 2;             // Cycles per sclk phase
  localparam int div_w = $clog2(SCLK_DIV);
  localparam int cnt_w = $clog2(frame_nibbles);

  logic [div_w-1:0] div_cnt;  // Position inside the current sclk phase
  logic [cnt_w-1:0] nib_cnt;  // Nibbles taken so far in this frame
  logic phase_end;
  logic sample;
  logic last_nib;

  assign phase_end = div_cnt == div_w'(half - 1);
  // sclk about to rise, ESP data is stable here
  assign sample = !cs_n && !sclk && phase_end;
  assign last_nib = nib_cnt == cnt_w'(frame_nibbles - 1);

  // Divider and nibble counter, chip select high drops a partial frame
  always_ff @(posedge clk) begin
    if (reset || cs_n) begin
      div_cnt <= '0;
      sclk <= 1'b0;        // Idle low
      nib_cnt <= '0;       // Next frame starts clean
    end else begin
      if (phase_end) begin
        div_cnt <= '0;
        sclk <= !sclk;     // Half period done
      end else begin
        div_cnt <= div_cnt + 1'b1;
      end
      if (sample) begin
        nib_cnt <= last_nib ? '0 : nib_cnt + 1'b1;  // Wrap for back-to-back frames
      end
    end
  end

  // One write per complete frame, the cycle after the tenth sample
  always_ff @(posedge clk) begin
    if (reset) begin
      wr_en <= 1'b0;
    end else begin
      wr_en <= sample && last_nib;
    end
  end

  // Frame payload, only meaningful while wr_en is high
  always_ff @(posedge clk) begin
    if (sample) begin
      if (nib_cnt < cnt_w'(addr_nibbles)) begin
        // Keeps the low index bits of the two address nibbles
        wr_addr <= {wr_addr[reg_addr_w-5:0], esp_data};
      end else begin
        wr_data <= {wr_data[data_w-5:0], esp_data};  // MSB nibble first
      end
    end
  end

endmodule

// File: ext_register_file.sv
module ext_register_file (
  input  logic clk,
  input  logic reset,
  input  logic wr_en,
  input  logic [mmio_pkg::reg_addr_w-1:0] wr_addr,
  input  logic [mmio_pkg::data_w-1:0] wr_data,
  reg_read_if.responder rd
);
  import mmio_pkg::*;

  logic [data_w-1:0] regs_q [reg_count];  // ESP32 supplied values

  // Storage, SPI side is the only writer
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < reg_count; i++) begin
        regs_q[i] <= '0;
      end
    end else if (wr_en) begin
      regs_q[wr_addr] <= wr_data;
    end
  end

  // Read handshake, ack one cycle after req
  always_ff @(posedge clk) begin
    if (reset) begin
      rd.ack <= 1'b0;
    end else begin
      rd.ack <= rd.req;
    end
  end

  // Read data
  // Same-cycle SPI write to this index is not seen yet, old value goes out
  always_ff @(posedge clk) begin
    if (rd.req) begin
      rd.data <= regs_q[rd.addr];
    end
  end

endmodule

// File: scratch_ram.sv
module scratch_ram (
  input  logic clk,
  input  logic reset,
  ram_port_if.responder port
);
  import mmio_pkg::*;

  logic [data_w-1:0] mem [ram_words];
  logic sweeping;                    // Clearing after reset
  logic [ram_addr_w-1:0] sweep_addr;
  logic pend;                        // Request seen during the sweep
  logic serve;
  logic mem_we;
  logic [ram_addr_w-1:0] mem_addr;
  logic [data_w-1:0] mem_wdata;

  assign serve = !sweeping && (port.req || pend);
  assign mem_we = sweeping || (serve && port.we);
  assign mem_addr = sweeping ? sweep_addr : port.addr;  // Sweep owns the port
  assign mem_wdata = sweeping ? '0 : port.wdata;

  always_ff @(posedge clk) begin
    if (reset) begin
      sweeping <= 1'b1;
      sweep_addr <= '0;
      pend <= 1'b0;
      port.ack <= 1'b0;
    end else begin
      port.ack <= serve;  // Held off until the sweep ends
      if (sweeping) begin
        sweep_addr <= sweep_addr + 1'b1;
        if (sweep_addr == ram_addr_w'(ram_words - 1)) sweeping <= 1'b0;
        if (port.req) pend <= 1'b1;
      end else begin
        pend <= 1'b0;     // Served this cycle
      end
    end
  end

  // Memory array, one write or one registered read per cycle
  always_ff @(posedge clk) begin
    if (mem_we) mem[mem_addr] <= mem_wdata;
    if (serve && !port.we) port.rdata <= mem[mem_addr];
  end

endmodule

// File: mmio_decoder.sv
module mmio_decoder (
  input  logic clk,
  input  logic reset,
  input  logic cyc,
  input  logic stb,
  input  logic we,
  input  logic [mmio_pkg::adr_w-1:0] adr,
  input  logic [mmio_pkg::data_w-1:0] dat_w,
  output logic [mmio_pkg::data_w-1:0] dat_r,
  output logic ack,
  reg_read_if.requester regs,
  ram_port_if.requester ram
);
  import mmio_pkg::*;

  // Region sizes in words, minus one
  localparam logic [adr_w-3:0] ram_span = ram_limit[adr_w-1:2] - ram_base[adr_w-1:2];
  localparam logic [adr_w-3:0] reg_span = reg_limit[adr_w-1:2] - reg_base[adr_w-1:2];

  logic [adr_w-3:0] ram_woff;  // Word offset into each region
  logic [adr_w-3:0] reg_woff;  // Wraps high when below the base
  region_t region;             // Region of the current address
  region_t sel_region;         // Region of the access in flight
  logic busy;                  // One access in flight
  logic start;
  logic local_req;             // Decoder answers this one itself
  logic local_ack;

  assign ram_woff = adr[adr_w-1:2] - ram_base[adr_w-1:2];
  assign reg_woff = adr[adr_w-1:2] - reg_base[adr_w-1:2];

  always_comb begin
    if (ram_woff <= ram_span) region = region_ram;
    else if (reg_woff <= reg_span) region = region_reg;
    else region = region_none;
  end

  assign start = cyc && stb && !busy;  // New access, not yet issued

  always_ff @(posedge clk) begin
    if (reset) begin
      busy <= 1'b0;
      sel_region <= region_none;
      ram.req <= 1'b0;
      regs.req <= 1'b0;
      local_req <= 1'b0;
      local_ack <= 1'b0;
    end else begin
      ram.req <= 1'b0;       // Pulses by default
      regs.req <= 1'b0;
      local_req <= 1'b0;
      local_ack <= local_req; // Same latency as the targets
      if (start) begin
        busy <= 1'b1;
        sel_region <= region;
        case (region)
          region_ram: ram.req <= 1'b1;
          region_reg: begin
            if (we) local_req <= 1'b1;  // Read-only window, write dropped
            else regs.req <= 1'b1;
          end
          default: local_req <= 1'b1;   // Unmapped
        endcase
      end else if (ack) begin
        busy <= 1'b0;        // Master drops stb next
      end
    end
  end

  // Target payload, held until the next access
  always_ff @(posedge clk) begin
    if (start) begin
      ram.we <= we;
      ram.addr <= ram_woff[ram_addr_w-1:0];
      ram.wdata <= dat_w;
      regs.addr <= reg_woff[reg_addr_w-1:0];
    end
  end

  // Only one source can be active per access
  assign ack = ram.ack | regs.ack | local_ack;

  always_comb begin
    case (sel_region)
      region_ram: dat_r = ram.rdata;
      region_reg: dat_r = regs.data;
      default: dat_r = '0;   // Unmapped reads return zero
    endcase
  end

endmodule

// File: mmio_subsystem.sv
module mmio_subsystem #(
  parameter int SCLK_DIV = 4  // clk cycles per SPI clock period
) (
  input  logic clk,
  input  logic reset,
  // Wishbone classic slave
  input  logic cyc,
  input  logic stb,
  input  logic we,
  input  logic [mmio_pkg::adr_w-1:0] adr,
  input  logic [mmio_pkg::data_w-1:0] dat_w,
  output logic [mmio_pkg::data_w-1:0] dat_r,
  output logic ack,
  // ESP32 link
  input  logic cs_n,
  input  logic [3:0] esp_data,
  output logic sclk
);
  import mmio_pkg::*;

  logic wr_en;                   // SPI write pulse
  logic [reg_addr_w-1:0] wr_addr;
  logic [data_w-1:0] wr_data;

  reg_read_if reg_rd ();         // Decoder to register file
  ram_port_if ram_port ();       // Decoder to RAM

  esp_spi_receiver #(
    .SCLK_DIV(SCLK_DIV)
  ) spi_rx (
    .clk(clk),
    .reset(reset),
    .cs_n(cs_n),
    .esp_data(esp_data),
    .sclk(sclk),
    .wr_en(wr_en),
    .wr_addr(wr_addr),
    .wr_data(wr_data)
  );

  ext_register_file ext_regs (
    .clk(clk),
    .reset(reset),
    .wr_en(wr_en),
    .wr_addr(wr_addr),
    .wr_data(wr_data),
    .rd(reg_rd.responder)
  );

  scratch_ram ram (.clk(clk), .reset(reset), .port(ram_port.responder));

  mmio_decoder decoder (
    .clk(clk),
    .reset(reset),
    .cyc(cyc),
    .stb(stb),
    .we(we),
    .adr(adr),
    .dat_w(dat_w),
    .dat_r(dat_r),
    .ack(ack),
    .regs(reg_rd.requester),
    .ram(ram_port.requester)
  );

endmodule

// File: mmio_checker.sv
module mmio_checker (
  input logic clk,
  input logic reset,
  input logic cyc,
  input logic stb,
  input logic ack,
  input logic cs_n,
  input logic sclk
);
  import mmio_pkg::*;

  logic [9:0] settle_cnt;  // Cycles since reset until the RAM is clear
  logic swept;

  assign swept = settle_cnt == 10'(ram_words + 1);

  always_ff @(posedge clk) begin
    if (reset) settle_cnt <= '0;
    else if (!swept) settle_cnt <= settle_cnt + 1'b1;
  end

  ack_in_cycle: assert property (@(posedge clk) disable iff (reset) ack |-> cyc && stb)
    else $error("ack outside an active bus cycle");
  ack_single: assert property (@(posedge clk) disable iff (reset) ack |=> !ack)
    else $error("ack held for two cycles");
  // Every region answers with the same latency
  ack_latency: assert property (@(posedge clk) disable iff (reset || !swept)
    $rose(cyc && stb) |-> ##2 ack)
    else $error("ack not two cycles after stb");
  sclk_idle: assert property (@(posedge clk) disable iff (reset) cs_n && $past(cs_n) |-> !sclk)
    else $error("sclk toggling with chip select high");

endmodule

bind mmio_subsystem mmio_checker mmio_chk (
  .clk(clk),
  .reset(reset),
  .cyc(cyc),
  .stb(stb),
  .ack(ack),
  .cs_n(cs_n),
  .sclk(sclk)
);

// File: tb_mmio_subsystem.sv
module tb_mmio_subsystem;
  import mmio_pkg::*;

  localparam int sclk_div = 4;
  localparam int frame_cycles = frame_nibbles * sclk_div + 8;  // Frame plus idle gap
  localparam int access_cycles = 6;  // Drive, two-cycle latency, release
  localparam int n_frames = 28;
  localparam int n_accesses = 243;
  localparam int timeout_cycles =
    4 * (ram_words + 8 + n_frames * frame_cycles + n_accesses * access_cycles);

  logic clk, reset, cyc, stb, we, ack, cs_n, sclk;
  logic [adr_w-1:0] adr;
  logic [data_w-1:0] dat_w, dat_r;
  logic [3:0] esp_data;

  logic [data_w-1:0] ref_regs [reg_count];  // Model of the SPI-loaded registers
  logic [data_w-1:0] ref_ram [ram_words];
  logic [data_w-1:0] exp_q [$];             // Expected read data in arrival order
  string name_q [$];
  logic [adr_w-1:0] ram_adr [32];           // Addresses used by the RAM test
  logic [31:0] lcg_state = 32'd69295;
  int errors = 0;
  int checks = 0;
  int cycle_cnt = 0;

  mmio_subsystem #(.SCLK_DIV(sclk_div)) DUT (.*);

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic logic [adr_w-1:0] rand_ram_addr();
    logic [31:0] r;
    r = next_rand();
    return {22'd0, r[31:24], 2'b00};  // Word aligned, inside the RAM region
  endfunction

  // Models the address map with RAM, the read-only register window and zeros elsewhere
  function automatic logic [data_w-1:0] expected_read(input logic [adr_w-1:0] addr);
    if (addr <= ram_limit) return ref_ram[addr[ram_addr_w+1:2]];
    else if (addr >= reg_base && addr <= reg_limit) return ref_regs[addr[reg_addr_w+1:2]];
    else return '0;
  endfunction

  task automatic check_value(input string name, input logic [data_w-1:0] expected,
                             input logic [data_w-1:0] actual);
    checks++;
    if (expected !== actual) begin
      errors++;
      $display("mismatch %s: expected %08h actual %08h", name, expected, actual);
    end
  endtask

  // ESP32 side changes the nibble only while sclk is low
  task automatic send_frame(input logic [reg_addr_w-1:0] idx, input logic [data_w-1:0] value,
                            input int nibs);
    logic [4*frame_nibbles-1:0] frame;
    frame = {3'b000, idx, value};  // Index in the low bits of the first two nibbles
    @(negedge clk);
    cs_n = 1'b0;
    for (int i = 0; i < nibs; i++) begin
      esp_data = frame[4*frame_nibbles-1-4*i -: 4];
      do @(negedge clk); while (!sclk);  // Taken on the rise
      do @(negedge clk); while (sclk);
    end
    cs_n = 1'b1;  // Early rise drops the frame
    if (nibs == frame_nibbles) ref_regs[idx] = value;
    repeat (2) @(negedge clk);
  endtask

  // Single Wishbone classic access held until one cycle past ack
  task automatic bus_access(input logic write, input logic [adr_w-1:0] addr,
                            input logic [data_w-1:0] wdata, input string name);
    @(negedge clk);
    cyc = 1'b1;
    stb = 1'b1;
    we = write;
    adr = addr;
    dat_w = wdata;
    if (!write) begin
      exp_q.push_back(expected_read(addr));
      name_q.push_back(name);
    end
    do @(negedge clk); while (!ack);
    @(negedge clk);
    cyc = 1'b0;
    stb = 1'b0;
    if (write && addr <= ram_limit) ref_ram[addr[ram_addr_w+1:2]] = wdata;  // Only RAM stores
  endtask

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // Compares every read response as it is acknowledged
  always @(negedge clk) begin
    if (ack && !we) begin
      if (exp_q.size() == 0) begin
        errors++;
        $display("Read acknowledged with no read outstanding");
      end else check_value(name_q.pop_front(), exp_q.pop_front(), dat_r);
    end
  end

  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt == timeout_cycles) begin
      $display("Timeout: tests still running after %0d cycles", cycle_cnt);
      $display("Finished with errors");
      $finish;
    end
  end

  initial begin
    logic [31:0] tmp;
    int j;
    reset = 1'b1;
    cyc = 1'b0;
    stb = 1'b0;
    we = 1'b0;
    adr = '0;
    dat_w = '0;
    cs_n = 1'b1;
    esp_data = '0;
    for (int i = 0; i < reg_count; i++) ref_regs[i] = '0;
    for (int i = 0; i < ram_words; i++) ref_ram[i] = '0;
    repeat (2) @(negedge clk);
    reset = 1'b0;
    repeat (ram_words) @(negedge clk);  // RAM clear sweep
    for (int i = 0; i < reg_count; i++) bus_access(1'b0, reg_base + 4 * i, '0, "reset_regs");
    for (int i = 0; i < 16; i++) bus_access(1'b0, rand_ram_addr(), '0, "reset_ram");
    for (int i = 0; i < 24; i++) begin
      tmp = next_rand();
      send_frame(tmp[31:27], next_rand(), frame_nibbles);
    end
    send_frame(5'd7, 32'hdead_beef, frame_nibbles);
    send_frame(5'd7, next_rand(), frame_nibbles);  // Overwrite of the same index
    for (int i = 0; i < reg_count; i++) bus_access(1'b0, reg_base + 4 * i, '0, "spi_regs");
    for (int i = 0; i < 32; i++) begin
      ram_adr[i] = rand_ram_addr();
      bus_access(1'b1, ram_adr[i], next_rand(), "ram_write");
    end
    for (int i = 31; i > 0; i--) begin  // Shuffle the read order
      tmp = next_rand();
      j = int'(tmp[31:16]) % (i + 1);
      tmp = ram_adr[i];
      ram_adr[i] = ram_adr[j];
      ram_adr[j] = tmp;
    end
    for (int i = 0; i < 32; i++) bus_access(1'b0, ram_adr[i], '0, "ram_shuffled");
    for (int i = 0; i < 8; i++) begin
      tmp = next_rand();
      bus_access(1'b1, reg_base + {25'd0, tmp[31:27], 2'b00}, next_rand(), "reg_write");
      bus_access(1'b0, reg_base + {25'd0, tmp[31:27], 2'b00}, '0, "reg_write_ignored");
    end
    bus_access(1'b0, reg_limit + 4, '0, "unmapped_edge");  // First word past the window
    for (int i = 0; i < 8; i++) begin
      tmp = next_rand();
      // Out of range upper bits over the word index of a RAM word under test
      bus_access(1'b0, {tmp[31:13], 1'b1, ram_adr[i][11:0]}, '0, "unmapped_read");
      bus_access(1'b1, {tmp[31:13], 1'b1, ram_adr[i][11:0]}, next_rand(), "unmapped_write");
    end
    for (int i = 0; i < reg_count; i++) bus_access(1'b0, reg_base + 4 * i, '0, "regs_kept");
    for (int i = 0; i < 32; i++) bus_access(1'b0, ram_adr[i], '0, "ram_kept");
    send_frame(5'd3, 32'h1234_5678, 6);  // Cut after six nibbles
    send_frame(5'd20, 32'hcafe_f00d, frame_nibbles);
    bus_access(1'b0, reg_base + 12, '0, "cut_frame");
    bus_access(1'b0, reg_base + 80, '0, "frame_after_cut");
    repeat (4) @(negedge clk);
    if (exp_q.size() != 0) begin
      errors++;
      $display("%0d read responses never arrived", exp_q.size());
    end
    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) $display("Finished with no errors");
    else $display("Finished with errors");
    $finish;
  end

endmodule

// File: project.f
mmio_pkg.sv
bus_ifs.sv
esp_spi_receiver.sv
ext_register_file.sv
scratch_ram.sv
mmio_decoder.sv
mmio_subsystem.sv
mmio_checker.sv
tb_mmio_subsystem.sv

// File: Makefile
TOP = tb_mmio_subsystem

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f project.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f project.f --top-module $(TOP)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "Finished with no errors"

clean:
	rm -rf obj_dir
